/* source/rs_macros.svh */
// Reservation station sizing
// Entry count, physical tag width and functional unit count shared by
// the packages and the RTL

`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// Station entries
`define RS_SIZE 8

// Physical register tag width
`define TAG_BITS 6

// Functional units, one issue slot each
`define NUM_FU 5

`endif

/* source/isa_pkg.sv */
// Instruction set types
// Functional unit kinds, physical register tags and operation fields

`include "rs_macros.svh"

package isa_pkg;

	// Unit kinds, value doubles as the issue slot index
	typedef enum logic [2:0] {
		fu_alu  = 3'd0,
		fu_ld   = 3'd1,
		fu_st   = 3'd2,
		fu_mult = 3'd3,
		fu_br   = 3'd4
	} fu_kind_t;

	// Renamed register number
	typedef logic [`TAG_BITS-1:0] phys_tag_t;

	// Operation fields carried through the station untouched
	// apart from fu, which steers issue
	typedef struct packed {
		logic [7:0] opcode;
		fu_kind_t   fu;
	} op_fields_t;

endpackage

/* source/rs_pkg.sv */
// Reservation station types
// Entry layout, dispatch packet, CDB broadcast and issue slot

`include "rs_macros.svh"

package rs_pkg;

	// One source operand, ready once its producer has broadcast
	typedef struct packed {
		logic              ready;
		isa_pkg::phys_tag_t tag;
	} src_tag_t;

	// Stored entry, 32 bits
	typedef struct packed {
		logic               busy;
		isa_pkg::op_fields_t op;
		isa_pkg::phys_tag_t  dest;
		src_tag_t           src1;
		src_tag_t           src2;
	} rs_entry_t;

	// Renamed instruction from dispatch, single cycle strobe
	typedef struct packed {
		logic               valid;
		isa_pkg::op_fields_t op;
		isa_pkg::phys_tag_t  dest;
		src_tag_t           src1;
		src_tag_t           src2;
	} dispatch_t;

	// Common data bus, at most one tag per cycle
	typedef struct packed {
		logic               valid;
		isa_pkg::phys_tag_t tag;
	} cdb_t;

	// Issue slot towards one functional unit
	typedef struct packed {
		logic               valid;
		isa_pkg::op_fields_t op;
		isa_pkg::phys_tag_t  dest;
		isa_pkg::phys_tag_t  src1;
		isa_pkg::phys_tag_t  src2;
	} issue_slot_t;

endpackage

/* source/rs_select.sv */
// Priority selector
// One-hot grant for the highest set request bit, zero when idle

module rs_select #(
	parameter int WIDTH = 8
) (
	input  logic [WIDTH-1:0] req,
	output logic [WIDTH-1:0] grant
);

	// Some request above bit i
	logic [WIDTH-1:0] above;

	always_comb begin
		above[WIDTH-1] = 1'b0;
		// Sweep down from the top bit
		for (int i = WIDTH - 2; i >= 0; i--) begin
			above[i] = above[i+1] | req[i+1];
		end
	end

	// Winner has no request above it
	assign grant = req & ~above;

endmodule

/* source/rs_wakeup.sv */
// Wakeup CAM
// Compares the CDB tag with both sources of every entry and of the
// packet being dispatched this cycle

`include "rs_macros.svh"

module rs_wakeup (
	input  rs_pkg::rs_entry_t   entries [`RS_SIZE],
	input  rs_pkg::dispatch_t   incoming,
	input  rs_pkg::cdb_t        cdb,
	output logic [`RS_SIZE-1:0] src1_hit,
	output logic [`RS_SIZE-1:0] src2_hit,
	output logic                in1_hit,
	output logic                in2_hit
);

	import rs_pkg::*;

	// Hit only on a live broadcast for a source still waiting
	function automatic logic tag_match(input src_tag_t src, input cdb_t bus);
		return bus.valid && !src.ready && (src.tag == bus.tag);
	endfunction

	// ------------------------------------------------------------------------
	// Stored entries, free slots never hit
	// ------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			src1_hit[i] = entries[i].busy && tag_match(entries[i].src1, cdb);
			src2_hit[i] = entries[i].busy && tag_match(entries[i].src2, cdb);
		end
	end

	// ------------------------------------------------------------------------
	// Incoming packet, catches a producer broadcasting during dispatch
	// ------------------------------------------------------------------------
	assign in1_hit = incoming.valid && tag_match(incoming.src1, cdb);
	assign in2_hit = incoming.valid && tag_match(incoming.src2, cdb);

endmodule

/* source/rs_table.sv */
// Station entry table
// Holds the entries, merges wakeup hits and the dispatch write into the
// next table, frees issued entries and tracks occupancy

`include "rs_macros.svh"

module rs_table (
	input  logic                       clock,
	input  logic                       reset,
	input  rs_pkg::dispatch_t          dispatch,
	input  logic [`RS_SIZE-1:0]        free_grant,
	input  logic [`RS_SIZE-1:0]        src1_hit,
	input  logic [`RS_SIZE-1:0]        src2_hit,
	input  logic                       in1_hit,
	input  logic                       in2_hit,
	input  logic [`RS_SIZE-1:0]        issue_grant,
	output rs_pkg::rs_entry_t          entries [`RS_SIZE],
	output rs_pkg::rs_entry_t          entries_next [`RS_SIZE],
	output logic [$clog2(`RS_SIZE):0]  count,
	output logic                       rs_full
);

	import rs_pkg::*;

	localparam int CNT_BITS = $clog2(`RS_SIZE) + 1;

	// Slot taking the dispatch packet, zero when no strobe or no free slot
	logic [`RS_SIZE-1:0] write_slot;
	logic                accepted;
	// Entries leaving this cycle
	logic [CNT_BITS-1:0] grant_cnt;

	assign write_slot = free_grant & {`RS_SIZE{dispatch.valid}};
	assign accepted   = |write_slot;

	// ------------------------------------------------------------------------
	// Next table
	// ------------------------------------------------------------------------
	always_comb begin
		rs_entry_t merged;
		for (int i = 0; i < `RS_SIZE; i++) begin
			merged = entries[i];
			// Wakeup merge
			merged.src1.ready = merged.src1.ready | src1_hit[i];
			merged.src2.ready = merged.src2.ready | src2_hit[i];
			// Dispatch write into the granted free slot
			// busy stays low here so the new entry cannot request this cycle
			if (write_slot[i]) begin
				merged.op         = dispatch.op;
				merged.dest       = dispatch.dest;
				merged.src1.tag   = dispatch.src1.tag;
				merged.src1.ready = dispatch.src1.ready | in1_hit;
				merged.src2.tag   = dispatch.src2.tag;
				merged.src2.ready = dispatch.src2.ready | in2_hit;
			end
			// Issuing entries are still present, freed at the edge
			entries_next[i] = merged;
		end
	end

	// ------------------------------------------------------------------------
	// Entry registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			entries[i] <= entries_next[i];
			// Busy from the edge after dispatch, cleared by issue
			entries[i].busy <= (entries_next[i].busy & ~issue_grant[i]) | write_slot[i];
			if (reset) begin
				entries[i].busy <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Occupancy
	// ------------------------------------------------------------------------
	always_comb begin
		grant_cnt = '0;
		for (int i = 0; i < `RS_SIZE; i++) begin
			grant_cnt = grant_cnt + CNT_BITS'(issue_grant[i]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + CNT_BITS'(accepted) - grant_cnt;
		end
	end

	// Full once every entry is busy
	assign rs_full = (count == CNT_BITS'(`RS_SIZE));

endmodule

/* source/rs_issue.sv */
// Issue stage
// Builds a request vector per functional unit, gates loads and stores on
// the queue busy signals, picks one entry per unit and registers it

`include "rs_macros.svh"

module rs_issue (
	input  logic                 clock,
	input  logic                 reset,
	input  rs_pkg::rs_entry_t    entries_next [`RS_SIZE],
	input  logic                 ld_blocked,
	input  logic                 st_blocked,
	output rs_pkg::issue_slot_t  issue [`NUM_FU],
	output logic [`RS_SIZE-1:0]  issue_grant
);

	import isa_pkg::*;
	import rs_pkg::*;

	// Busy with both operands ready
	logic [`RS_SIZE-1:0] ready;
	// Per unit request and grant
	logic [`RS_SIZE-1:0] unit_req   [`NUM_FU];
	logic [`RS_SIZE-1:0] unit_grant [`NUM_FU];
	// Slot contents for the next edge
	issue_slot_t         slot_next  [`NUM_FU];

	// ------------------------------------------------------------------------
	// Requests
	// ------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			ready[i] = entries_next[i].busy
				&& entries_next[i].src1.ready
				&& entries_next[i].src2.ready;
		end
		// Steer by unit kind, slot index equals kind value
		for (int f = 0; f < `NUM_FU; f++) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				unit_req[f][i] = ready[i] && (entries_next[i].op.fu == fu_kind_t'(f));
			end
		end
		// Memory ops wait while the load or store queue is busy
		if (ld_blocked) begin
			unit_req[fu_ld] = '0;
		end
		if (st_blocked) begin
			unit_req[fu_st] = '0;
		end
	end

	// ------------------------------------------------------------------------
	// Selection, highest entry per unit
	// ------------------------------------------------------------------------
	for (genvar f = 0; f < `NUM_FU; f++) begin : g_sel
		rs_select #(
			.WIDTH (`RS_SIZE)
		) u_rs_select (
			.req   (unit_req[f]),
			.grant (unit_grant[f])
		);
	end

	// Entries freed at the next edge
	always_comb begin
		issue_grant = '0;
		for (int f = 0; f < `NUM_FU; f++) begin
			issue_grant = issue_grant | unit_grant[f];
		end
	end

	// One-hot mux of the granted entry into each slot
	always_comb begin
		rs_entry_t pick;
		for (int f = 0; f < `NUM_FU; f++) begin
			pick = '0;
			for (int i = 0; i < `RS_SIZE; i++) begin
				if (unit_grant[f][i]) begin
					pick = entries_next[i];
				end
			end
			slot_next[f].valid = |unit_grant[f];
			slot_next[f].op    = pick.op;
			slot_next[f].dest  = pick.dest;
			slot_next[f].src1  = pick.src1.tag;
			slot_next[f].src2  = pick.src2.tag;
		end
	end

	// ------------------------------------------------------------------------
	// Issue registers, unit always takes what it is given
	// ------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		for (int f = 0; f < `NUM_FU; f++) begin
			issue[f] <= slot_next[f];
			if (reset) begin
				issue[f].valid <= 1'b0;
			end
		end
	end

endmodule

/* source/rs_top.sv */
// Reservation station top level
// Entry table, wakeup CAM, dispatch slot selector and issue stage for a
// scalar core with five functional units

`include "rs_macros.svh"

module rs_top (
	input  logic                      clock,
	input  logic                      reset,
	input  rs_pkg::dispatch_t         dispatch,
	input  rs_pkg::cdb_t              cdb,
	input  logic                      ld_blocked,
	input  logic                      st_blocked,
	output rs_pkg::issue_slot_t       issue [`NUM_FU],
	output logic [$clog2(`RS_SIZE):0] count,
	output logic                      rs_full
);

	import rs_pkg::*;

	// Table state and next state
	rs_entry_t           entries      [`RS_SIZE];
	rs_entry_t           entries_next [`RS_SIZE];
	logic [`RS_SIZE-1:0] busy;
	// Wakeup results
	logic [`RS_SIZE-1:0] src1_hit;
	logic [`RS_SIZE-1:0] src2_hit;
	logic                in1_hit;
	logic                in2_hit;
	// Slot grants
	logic [`RS_SIZE-1:0] free_grant;
	logic [`RS_SIZE-1:0] issue_grant;

	for (genvar i = 0; i < `RS_SIZE; i++) begin : g_busy
		assign busy[i] = entries[i].busy;
	end

	rs_table u_rs_table (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.free_grant   (free_grant),
		.src1_hit     (src1_hit),
		.src2_hit     (src2_hit),
		.in1_hit      (in1_hit),
		.in2_hit      (in2_hit),
		.issue_grant  (issue_grant),
		.entries      (entries),
		.entries_next (entries_next),
		.count        (count),
		.rs_full      (rs_full)
	);

	rs_wakeup u_rs_wakeup (
		.entries  (entries),
		.incoming (dispatch),
		.cdb      (cdb),
		.src1_hit (src1_hit),
		.src2_hit (src2_hit),
		.in1_hit  (in1_hit),
		.in2_hit  (in2_hit)
	);

	// Dispatch goes to the highest free entry
	rs_select #(
		.WIDTH (`RS_SIZE)
	) u_dispatch_select (
		.req   (~busy),
		.grant (free_grant)
	);

	rs_issue u_rs_issue (
		.clock        (clock),
		.reset        (reset),
		.entries_next (entries_next),
		.ld_blocked   (ld_blocked),
		.st_blocked   (st_blocked),
		.issue        (issue),
		.issue_grant  (issue_grant)
	);

endmodule

/* tb/rs_top_assert.sv */
// Reservation station protocol assertions
// Bound to the top level, checks idle slots after reset, the occupancy
// bound and that a full station ignores dispatch

`include "rs_macros.svh"

module rs_top_assert (
	input logic                      clock,
	input logic                      reset,
	input rs_pkg::dispatch_t         dispatch,
	input rs_pkg::issue_slot_t       issue [`NUM_FU],
	input logic [$clog2(`RS_SIZE):0] count,
	input logic                      rs_full
);

	localparam int CNT_BITS = $clog2(`RS_SIZE) + 1;
	localparam logic [CNT_BITS-1:0] MAX_COUNT = CNT_BITS'(`RS_SIZE);

	// Slot valid bits as one vector
	logic [`NUM_FU-1:0] issue_valid;

	always_comb begin
		for (int f = 0; f < `NUM_FU; f++) begin
			issue_valid[f] = issue[f].valid;
		end
	end

	// All slots idle one cycle after reset
	assert property (@(posedge clock) reset |=> (issue_valid == '0))
		else $error("issue slot valid in the cycle after reset");

	// Occupancy bounded by entry count
	assert property (@(posedge clock) disable iff (reset) count <= MAX_COUNT)
		else $error("count above the number of entries");

	// Dispatch into a full station is dropped
	assert property (@(posedge clock) disable iff (reset)
		(dispatch.valid && rs_full) |=> (count <= $past(count)))
		else $error("count rose after a dispatch while full");

endmodule

bind rs_top rs_top_assert u_rs_top_assert (
	.clock    (clock),
	.reset    (reset),
	.dispatch (dispatch),
	.issue    (issue),
	.count    (count),
	.rs_full  (rs_full)
);

/* tb/rs_top_tb.sv */
// Reservation station testbench
// Per-cycle stimulus table checked against a reference model of the
// dispatch, wakeup, issue and occupancy rules

`include "rs_macros.svh"

module rs_top_tb;

	import isa_pkg::*;
	import rs_pkg::*;

	localparam int CNT_BITS = $clog2(`RS_SIZE) + 1;
	// No dispatch, or no broadcast, in a row
	localparam int NONE = -1;

	// One table row, held for one cycle
	typedef struct packed {
		dispatch_t disp;
		cdb_t      bus;
		logic      ld_blk;
		logic      st_blk;
	} row_t;

	logic                clock;
	logic                reset;
	dispatch_t           dispatch;
	cdb_t                cdb;
	logic                ld_blocked;
	logic                st_blocked;
	issue_slot_t         issue [`NUM_FU];
	logic [CNT_BITS-1:0] count;
	logic                rs_full;

	// Stimulus table and reference model state
	row_t                rows [$];
	rs_entry_t           model [`RS_SIZE];
	issue_slot_t         exp_issue [`NUM_FU];
	logic [CNT_BITS-1:0] exp_count;
	int                  errors;
	int                  checks;
	int                  cycles;

	rs_top u_rs_top (
		.clock      (clock),
		.reset      (reset),
		.dispatch   (dispatch),
		.cdb        (cdb),
		.ld_blocked (ld_blocked),
		.st_blocked (st_blocked),
		.issue      (issue),
		.count      (count),
		.rs_full    (rs_full)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Run limit from the table length
	initial begin
		cycles = 0;
		while (cycles < rows.size() + 20) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: run did not finish after %0d cycles", cycles);
		$display("Testbench failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Table rows
	// waits bit 0 holds src1 back, bit 1 src2; blk bit 0 loads, bit 1 stores
	// ------------------------------------------------------------------------
	task automatic add_row(input int kind, input int dest, input int t1, input int t2,
			input int waits, input int bus, input int blk);
		row_t r;
		r = '0;
		if (kind != NONE) begin
			r.disp.valid      = 1'b1;
			r.disp.op.opcode  = 8'(dest + 64);
			r.disp.op.fu      = fu_kind_t'(kind);
			r.disp.dest       = phys_tag_t'(dest);
			r.disp.src1.tag   = phys_tag_t'(t1);
			r.disp.src1.ready = (waits & 1) == 0;
			r.disp.src2.tag   = phys_tag_t'(t2);
			r.disp.src2.ready = (waits & 2) == 0;
		end
		if (bus != NONE) begin
			r.bus.valid = 1'b1;
			r.bus.tag   = phys_tag_t'(bus);
		end
		r.ld_blk = blk[0];
		r.st_blk = blk[1];
		rows.push_back(r);
	endtask

	// ------------------------------------------------------------------------
	// Reference model, one cycle per row
	// ------------------------------------------------------------------------
	task automatic step_model(input row_t r);
		rs_entry_t nxt [`RS_SIZE];
		int        fu;
		int        slot;
		int        delta;
		logic      gated;
		// Wakeup of busy entries
		for (int i = 0; i < `RS_SIZE; i++) begin
			nxt[i] = model[i];
			if (model[i].busy && r.bus.valid && model[i].src1.tag == r.bus.tag) begin
				nxt[i].src1.ready = 1'b1;
			end
			if (model[i].busy && r.bus.valid && model[i].src2.tag == r.bus.tag) begin
				nxt[i].src2.ready = 1'b1;
			end
		end
		// Highest ready entry per unit, seen through the woken table
		delta = 0;
		for (int f = 0; f < `NUM_FU; f++) begin
			exp_issue[f] = '0;
		end
		for (int i = `RS_SIZE - 1; i >= 0; i--) begin
			fu = int'(nxt[i].op.fu);
			gated = (nxt[i].op.fu == fu_ld && r.ld_blk) || (nxt[i].op.fu == fu_st && r.st_blk);
			if (nxt[i].busy && nxt[i].src1.ready && nxt[i].src2.ready && !gated
					&& !exp_issue[fu].valid) begin
				exp_issue[fu].valid = 1'b1;
				exp_issue[fu].op    = nxt[i].op;
				exp_issue[fu].dest  = nxt[i].dest;
				exp_issue[fu].src1  = nxt[i].src1.tag;
				exp_issue[fu].src2  = nxt[i].src2.tag;
				nxt[i].busy = 1'b0;
				delta--;
			end
		end
		// Free slot judged at the start of the cycle
		slot = NONE;
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (!model[i].busy) begin
				slot = i;
			end
		end
		if (r.disp.valid && slot != NONE) begin
			nxt[slot].busy = 1'b1;
			nxt[slot].op   = r.disp.op;
			nxt[slot].dest = r.disp.dest;
			nxt[slot].src1 = r.disp.src1;
			nxt[slot].src2 = r.disp.src2;
			// Producer broadcasting during dispatch
			if (r.bus.valid && r.disp.src1.tag == r.bus.tag) begin
				nxt[slot].src1.ready = 1'b1;
			end
			if (r.bus.valid && r.disp.src2.tag == r.bus.tag) begin
				nxt[slot].src2.ready = 1'b1;
			end
			delta++;
		end
		exp_count = CNT_BITS'(int'(exp_count) + delta);
		model = nxt;
	endtask

	// Mid-cycle comparison, slot fields only matter when valid
	task automatic compare_outputs();
		logic exp_full;
		exp_full = (exp_count == CNT_BITS'(`RS_SIZE));
		for (int f = 0; f < `NUM_FU; f++) begin
			checks++;
			if (issue[f].valid !== exp_issue[f].valid) begin
				$display("MISMATCH t=%0t issue[%0d].valid got %0b expected %0b",
					$time, f, issue[f].valid, exp_issue[f].valid);
				errors++;
			end else if (exp_issue[f].valid && issue[f] !== exp_issue[f]) begin
				$display("MISMATCH t=%0t issue[%0d] got %h expected %h",
					$time, f, issue[f], exp_issue[f]);
				errors++;
			end
		end
		checks += 2;
		if (count !== exp_count) begin
			$display("MISMATCH t=%0t count got %0d expected %0d", $time, count, exp_count);
			errors++;
		end
		if (rs_full !== exp_full) begin
			$display("MISMATCH t=%0t rs_full got %0b expected %0b", $time, rs_full, exp_full);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		errors     = 0;
		checks     = 0;
		reset      = 1'b1;
		dispatch   = '0;
		cdb        = '0;
		ld_blocked = 1'b0;
		st_blocked = 1'b0;
		exp_count  = '0;
		for (int i = 0; i < `RS_SIZE; i++) begin
			model[i] = '0;
		end
		for (int f = 0; f < `NUM_FU; f++) begin
			exp_issue[f] = '0;
		end

		// Ready ALU op, out two cycles later
		add_row(fu_alu, 10, 1, 2, 0, NONE, 0);
		repeat (2) add_row(NONE, 0, 0, 0, 0, NONE, 0);
		// Mult waiting on two tags, first one broadcast during dispatch
		add_row(fu_mult, 11, 20, 21, 3, 20, 0);
		add_row(NONE, 0, 0, 0, 0, NONE, 0);
		add_row(NONE, 0, 0, 0, 0, 21, 0);
		add_row(NONE, 0, 0, 0, 0, NONE, 0);
		// Three ALU ops and a branch woken together
		add_row(fu_alu, 12, 30, 3, 1, NONE, 0);
		add_row(fu_alu, 13, 30, 3, 1, NONE, 0);
		add_row(fu_alu, 14, 30, 3, 1, NONE, 0);
		add_row(fu_br, 15, 30, 3, 1, NONE, 0);
		add_row(NONE, 0, 0, 0, 0, 30, 0);
		repeat (3) add_row(NONE, 0, 0, 0, 0, NONE, 0);
		// Load and store held by the queue gates
		add_row(fu_ld, 16, 4, 5, 0, NONE, 3);
		add_row(fu_st, 17, 6, 7, 0, NONE, 3);
		add_row(NONE, 0, 0, 0, 0, NONE, 3);
		add_row(NONE, 0, 0, 0, 0, NONE, 2);
		repeat (2) add_row(NONE, 0, 0, 0, 0, NONE, 0);
		// Fill all eight entries, ninth dispatch dropped
		add_row(fu_alu, 18, 40, 8, 1, NONE, 0);
		add_row(fu_ld, 19, 40, 8, 1, NONE, 0);
		add_row(fu_st, 20, 40, 8, 1, NONE, 0);
		add_row(fu_mult, 21, 40, 8, 1, NONE, 0);
		add_row(fu_br, 22, 40, 8, 1, NONE, 0);
		add_row(fu_alu, 23, 9, 40, 2, NONE, 0);
		add_row(fu_mult, 24, 9, 40, 2, NONE, 0);
		add_row(fu_br, 25, 40, 40, 3, NONE, 0);
		add_row(fu_alu, 26, 1, 2, 0, NONE, 0);
		add_row(NONE, 0, 0, 0, 0, NONE, 0);
		add_row(NONE, 0, 0, 0, 0, 40, 0);
		repeat (3) add_row(NONE, 0, 0, 0, 0, NONE, 0);

		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		compare_outputs();

		// Row k drives cycle k, outputs seen mid-cycle reflect row k-1
		foreach (rows[k]) begin
			@(posedge clock);
			dispatch   <= rows[k].disp;
			cdb        <= rows[k].bus;
			ld_blocked <= rows[k].ld_blk;
			st_blocked <= rows[k].st_blk;
			@(negedge clock);
			compare_outputs();
			step_model(rows[k]);
		end
		@(posedge clock);
		dispatch   <= '0;
		cdb        <= '0;
		ld_blocked <= 1'b0;
		st_blocked <= 1'b0;
		@(negedge clock);
		compare_outputs();

		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+source
source/isa_pkg.sv
source/rs_pkg.sv
source/rs_select.sv
source/rs_wakeup.sv
source/rs_table.sv
source/rs_issue.sv
source/rs_top.sv
tb/rs_top_assert.sv
tb/rs_top_tb.sv

/* Makefile */
# Verilator build and run of the reservation station testbench

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: run clean

run: obj_dir/Vrs_top_tb
	obj_dir/Vrs_top_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Testbench failed" sim.log
	grep -q "Testbench passed" sim.log

obj_dir/Vrs_top_tb: project.f $(SOURCES)
	verilator --binary --timing --assert --top-module rs_top_tb -f project.f -o Vrs_top_tb

clean:
	rm -rf obj_dir sim.log
